/* filelist.f */
+incdir+design
design/channel_sum_pkg.sv
design/pixel_channel_counter.sv
design/partial_sum_ram.sv
design/channel_accumulator.sv
design/channel_sum_top.sv
dv/tb_clock_gen.sv
dv/tb_channel_sum.sv

/* run.sh */
#!/bin/sh
# build and run the channel sum testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_channel_sum -Mdir "$obj" -f filelist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$obj/Vtb_channel_sum" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$log"; then
	exit 1
fi

exit 0

/* dv/tb_channel_sum.sv */
`include "channel_sum_consts.svh"

module tb_channel_sum;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRAIN_LIMIT = 200;
	localparam int RESET_LIMIT = 100;
	localparam int LAST_CHAN   = `CS_CHANNEL_NUM - 1;

	logic                    clk;
	logic                    reset;
	logic                    valid_in;
	channel_sum_pkg::pixel_t pxl_in;
	logic                    valid_out;
	channel_sum_pkg::pixel_t pxl_out;

	// one frame of input, channel-major
	channel_sum_pkg::pixel_t frame [`CS_CHANNEL_NUM][`CS_IMAGE_SIZE];

	// expected sums and the cycle each one should be seen in
	channel_sum_pkg::pixel_t exp_val_q [$];
	int                      exp_cyc_q [$];

	logic [31:0] lfsr_state;
	int          cycle;
	int          out_count;
	int          checks;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_err_base;
	bit          timed_out;
	string       cur_test;

	tb_clock_gen #(.HALF_PERIOD(4), .RESET_CYCLES(16)) i_clock (
		.clk   (clk),
		.reset (reset)
	);

	channel_sum_top i_dut (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.pxl_in    (pxl_in),
		.valid_out (valid_out),
		.pxl_out   (pxl_out)
	);

	// only read at falling edges
	always @(posedge clk) begin
		cycle = cycle + 1;
	end

	////////////////////
	// random source
	////////////////////

	// galois form, one step per bit
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	////////////////////
	// reference and checks
	////////////////////

	// sum of one pixel over every channel, wrapping at the word width
	function automatic channel_sum_pkg::pixel_t ref_sum(int p);
		channel_sum_pkg::pixel_t acc;
		acc = '0;
		for (int c = 0; c < `CS_CHANNEL_NUM; c++) begin
			acc = acc + frame[c][p];
		end
		return acc;
	endfunction

	task automatic check_word(string what, channel_sum_pkg::pixel_t exp,
			channel_sum_pkg::pixel_t act);
		checks++;
		assert (act === exp) else begin
			$display("mismatch %s %s: expected 0x%08h, actual 0x%08h",
				cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(string what, int exp, int act);
		checks++;
		assert (act == exp) else begin
			$display("mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			errors++;
		end
	endtask

	// compare process, outputs are settled at the falling edge
	always @(negedge clk) begin : compare
		channel_sum_pkg::pixel_t exp_val;
		int                      exp_cyc;
		if (valid_out === 1'b1) begin
			out_count++;
			checks++;
			assert (exp_val_q.size() != 0) else begin
				$display("%s: valid_out pulsed while no result was pending", cur_test);
				errors++;
			end
			if (exp_val_q.size() != 0) begin
				exp_val = exp_val_q.pop_front();
				exp_cyc = exp_cyc_q.pop_front();
				check_word("sum", exp_val, pxl_out);
				check_count("output cycle", exp_cyc, cycle);
			end
		end
	end

	////////////////////
	// stimulus
	////////////////////

	task automatic idle_cycles(int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			valid_in = 1'b0;
			pxl_in   = rand_bits(32);
		end
	endtask

	// sampled at the next rising edge, seen on valid_out two edges later
	task automatic drive_pixel(int c, int p);
		@(negedge clk);
		valid_in = 1'b1;
		pxl_in   = frame[c][p];
		if (c == LAST_CHAN) begin
			exp_val_q.push_back(ref_sum(p));
			exp_cyc_q.push_back(cycle + 2);
		end
	endtask

	task automatic drive_channels(int first_c, int last_c, bit gaps);
		int gap;
		for (int c = first_c; c <= last_c; c++) begin
			for (int p = 0; p < `CS_IMAGE_SIZE; p++) begin
				if (gaps) begin
					gap = rand_bits(2);
					// now and then a longer pause
					if (gap == 3) begin
						gap = gap + rand_bits(3);
					end
					idle_cycles(gap);
				end
				drive_pixel(c, p);
			end
		end
	endtask

	task automatic fill_counting(int base);
		for (int c = 0; c < `CS_CHANNEL_NUM; c++) begin
			for (int p = 0; p < `CS_IMAGE_SIZE; p++) begin
				frame[c][p] = base + c * `CS_IMAGE_SIZE + p + 1;
			end
		end
	endtask

	task automatic fill_random();
		for (int c = 0; c < `CS_CHANNEL_NUM; c++) begin
			for (int p = 0; p < `CS_IMAGE_SIZE; p++) begin
				frame[c][p] = rand_bits(32);
			end
		end
	endtask

	// every pixel close to the top of the range
	task automatic fill_near_top();
		for (int c = 0; c < `CS_CHANNEL_NUM; c++) begin
			for (int p = 0; p < `CS_IMAGE_SIZE; p++) begin
				frame[c][p] = 32'hffff_ff00 | rand_bits(8);
			end
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_val_q.size() != 0 && n < DRAIN_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (exp_val_q.size() != 0) begin
			$display("timeout in %s: %0d expected results never came out",
				cur_test, exp_val_q.size());
			timed_out = 1'b1;
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic start_test(string name);
		cur_test      = name;
		test_err_base = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_err_base) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errors - test_err_base);
		end
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_reset_quiet();
		int n;
		bit released;
		start_test("reset_quiet");
		n        = 0;
		released = 1'b0;
		while (!released && n < RESET_LIMIT) begin
			@(negedge clk);
			check_count("valid_out in reset", 0, valid_out);
			released = !reset;
			n++;
		end
		if (!released) begin
			$display("timeout in %s: reset was never released", cur_test);
			timed_out = 1'b1;
		end else begin
			repeat (8) begin
				@(negedge clk);
				check_count("valid_out after reset", 0, valid_out);
			end
		end
		end_test();
	endtask

	task automatic test_counting_frame();
		int base;
		if (timed_out) return;
		start_test("counting_frame");
		base = out_count;
		fill_counting(0);
		drive_channels(0, LAST_CHAN, 1'b0);
		idle_cycles(1);
		wait_drain();
		check_count("output count", `CS_IMAGE_SIZE, out_count - base);
		end_test();
	endtask

	task automatic test_random_gaps();
		int base;
		if (timed_out) return;
		start_test("random_gaps");
		base = out_count;
		for (int f = 0; f < 2; f++) begin
			fill_random();
			drive_channels(0, LAST_CHAN, 1'b1);
		end
		idle_cycles(1);
		wait_drain();
		check_count("output count", 2 * `CS_IMAGE_SIZE, out_count - base);
		end_test();
	endtask

	// second frame follows the first with no idle cycle
	task automatic test_back_to_back();
		int base;
		if (timed_out) return;
		start_test("back_to_back");
		base = out_count;
		fill_counting(1000);
		drive_channels(0, LAST_CHAN, 1'b0);
		fill_random();
		drive_channels(0, LAST_CHAN, 1'b0);
		idle_cycles(1);
		wait_drain();
		check_count("output count", 2 * `CS_IMAGE_SIZE, out_count - base);
		end_test();
	endtask

	task automatic test_overflow();
		int base;
		if (timed_out) return;
		start_test("overflow");
		base = out_count;
		fill_near_top();
		drive_channels(0, LAST_CHAN, 1'b0);
		idle_cycles(1);
		wait_drain();
		check_count("output count", `CS_IMAGE_SIZE, out_count - base);
		end_test();
	endtask

	task automatic test_no_early_output();
		int base;
		if (timed_out) return;
		start_test("no_early_output");
		fill_random();
		base = out_count;
		drive_channels(0, LAST_CHAN - 1, 1'b1);
		idle_cycles(4);
		@(posedge clk);
		check_count("pulses before last channel", 0, out_count - base);
		drive_channels(LAST_CHAN, LAST_CHAN, 1'b1);
		idle_cycles(1);
		wait_drain();
		check_count("output count", `CS_IMAGE_SIZE, out_count - base);
		end_test();
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		valid_in     = 1'b0;
		pxl_in       = '0;
		lfsr_state   = 32'hdb4c_5517;
		cycle        = 0;
		out_count    = 0;
		checks       = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		cur_test     = "init";

		test_reset_quiet();
		test_counting_frame();
		test_random_gaps();
		test_back_to_back();
		test_overflow();
		test_no_early_output();

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (timed_out || errors != 0) begin
			$display("tests failed");
		end else begin
			$display("all tests passed");
		end
		$finish;
	end

endmodule

/* dv/tb_clock_gen.sv */
module tb_clock_gen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// release on a falling edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
	end

endmodule

/* design/channel_sum_top.sv */
module channel_sum_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      valid_in,
	input  channel_sum_pkg::pixel_t   pxl_in,
	output logic                      valid_out,
	output channel_sum_pkg::pixel_t   pxl_out
);

	////////////////////
	// internal wiring
	////////////////////

	channel_sum_pkg::pxl_pos_t  pos;
	channel_sum_pkg::pxl_addr_t rd_addr;
	channel_sum_pkg::pixel_t    rd_data;
	logic                       wr_en;
	channel_sum_pkg::pxl_addr_t wr_addr;
	channel_sum_pkg::pixel_t    wr_data;

	// position and channel of the next input
	pixel_channel_counter i_counter (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.pos      (pos)
	);

	// running sums, one per pixel
	partial_sum_ram i_ram (
		.clk      (clk),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	// read, add, write back, emit
	channel_accumulator i_accum (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.pxl_in    (pxl_in),
		.pos       (pos),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.valid_out (valid_out),
		.pxl_out   (pxl_out)
	);

endmodule

/* design/channel_accumulator.sv */
module channel_accumulator (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         valid_in,
	input  channel_sum_pkg::pixel_t      pxl_in,
	input  channel_sum_pkg::pxl_pos_t    pos,
	output channel_sum_pkg::pxl_addr_t   rd_addr,
	input  channel_sum_pkg::pixel_t      rd_data,
	output logic                         wr_en,
	output channel_sum_pkg::pxl_addr_t   wr_addr,
	output channel_sum_pkg::pixel_t      wr_data,
	output logic                         valid_out,
	output channel_sum_pkg::pixel_t      pxl_out
);

	channel_sum_pkg::pxl_beat_t beat_in;
	channel_sum_pkg::pxl_beat_t stage;
	channel_sum_pkg::pixel_t    sum;
	logic                       emit;

	////////////////////
	// stage one
	////////////////////

	// gather the input strobe, data and position
	always_comb begin
		beat_in.valid = valid_in;
		beat_in.data  = pxl_in;
		beat_in.pos   = pos;
	end

	// fetch the running sum for the incoming pixel
	assign rd_addr = pos.addr;

	// payload only loads on a real beat
	always_ff @(posedge clk) begin
		if (reset) begin
			stage.valid <= 1'b0;
		end else if (valid_in) begin
			stage <= beat_in;
		end else begin
			stage.valid <= 1'b0;
		end
	end

	////////////////////
	// stage two
	////////////////////

	// first channel starts a fresh sum, stored word is stale
	always_comb begin
		if (stage.pos.first_chan) begin
			sum = stage.data;
		end else begin
			sum = rd_data + stage.data;
		end
	end

	// write back to the same position
	assign wr_en   = stage.valid;
	assign wr_addr = stage.pos.addr;
	assign wr_data = sum;

	// finished sum on the last channel
	assign emit = stage.valid && stage.pos.last_chan;

	////////////////////
	// output
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= emit;
		end
	end

	// holds the last finished sum between strobes
	always_ff @(posedge clk) begin
		if (emit) begin
			pxl_out <= sum;
		end
	end

	////////////////////
	// checks
	////////////////////

	// every output strobe comes from a last-channel input two edges earlier
	a_out_after_last: assert property (
		@(posedge clk) disable iff (reset)
		valid_out |-> $past(valid_in && pos.last_chan, 2)
	) else $error("valid_out without a last-channel input");

endmodule

/* design/partial_sum_ram.sv */
`include "channel_sum_consts.svh"

module partial_sum_ram (
	input  logic                         clk,
	input  channel_sum_pkg::pxl_addr_t   rd_addr,
	output channel_sum_pkg::pixel_t      rd_data,
	input  logic                         wr_en,
	input  channel_sum_pkg::pxl_addr_t   wr_addr,
	input  channel_sum_pkg::pixel_t      wr_data
);

	////////////////////
	// storage
	////////////////////

	// one running sum per pixel position
	channel_sum_pkg::pixel_t mem [`CS_IMAGE_SIZE];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read, word valid one edge after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

	////////////////////
	// checks
	////////////////////

	// write-back trails the read address by one pixel,
	// so the two ports never meet on one word
	a_no_collision: assert property (
		@(posedge clk)
		wr_en |-> (wr_addr != rd_addr)
	) else $error("read and write hit the same address");

endmodule

/* design/pixel_channel_counter.sv */
`include "channel_sum_consts.svh"

module pixel_channel_counter (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        valid_in,
	output channel_sum_pkg::pxl_pos_t   pos
);

	////////////////////
	// counters
	////////////////////

	channel_sum_pkg::pxl_addr_t pxl_cnt;
	channel_sum_pkg::chan_idx_t chan_cnt;

	logic last_pxl;
	logic last_chan;

	// end of one channel image
	assign last_pxl  = (pxl_cnt == channel_sum_pkg::pxl_addr_t'(`CS_IMAGE_SIZE - 1));
	// final channel of the frame
	assign last_chan = (chan_cnt == channel_sum_pkg::chan_idx_t'(`CS_CHANNEL_NUM - 1));

	// pixel index steps on every accepted input
	always_ff @(posedge clk) begin
		if (reset) begin
			pxl_cnt <= '0;
		end else if (valid_in) begin
			if (last_pxl) begin
				pxl_cnt <= '0;
			end else begin
				pxl_cnt <= pxl_cnt + 1'b1;
			end
		end
	end

	// channel index steps once per full image
	always_ff @(posedge clk) begin
		if (reset) begin
			chan_cnt <= '0;
		end else if (valid_in && last_pxl) begin
			if (last_chan) begin
				chan_cnt <= '0;
			end else begin
				chan_cnt <= chan_cnt + 1'b1;
			end
		end
	end

	////////////////////
	// position of the next input
	////////////////////

	always_comb begin
		pos.addr       = pxl_cnt;
		pos.first_chan = (chan_cnt == '0);
		pos.last_chan  = last_chan;
	end

	////////////////////
	// checks
	////////////////////

	// both counts wrap before leaving their range
	a_cnt_in_range: assert property (
		@(posedge clk) disable iff (reset)
		(pxl_cnt < `CS_IMAGE_SIZE) && (chan_cnt < `CS_CHANNEL_NUM)
	) else $error("pixel or channel count out of range");

endmodule

/* design/channel_sum_pkg.sv */
`include "channel_sum_consts.svh"

package channel_sum_pkg;

	////////////////////
	// scalar words
	////////////////////

	// one pixel, or one running sum of pixels
	typedef logic [`CS_DATA_WIDTH-1:0] pixel_t;

	// position inside one channel image
	typedef logic [`CS_ADDR_WIDTH-1:0] pxl_addr_t;

	// which input channel is streaming
	typedef logic [`CS_CHAN_WIDTH-1:0] chan_idx_t;

	////////////////////
	// bundles
	////////////////////

	// where a pixel sits in the frame
	typedef struct packed {
		pxl_addr_t addr;
		logic      first_chan;
		logic      last_chan;
	} pxl_pos_t;

	// one accepted input as held in the pipeline
	typedef struct packed {
		logic     valid;
		pixel_t   data;
		pxl_pos_t pos;
	} pxl_beat_t;

endpackage

/* design/channel_sum_consts.svh */
`ifndef CHANNEL_SUM_CONSTS_SVH
`define CHANNEL_SUM_CONSTS_SVH

// pixel and partial sum word
`define CS_DATA_WIDTH 32

// image geometry, one channel
`define CS_IMAGE_WIDTH 4
`define CS_IMAGE_HEIGHT 4
`define CS_IMAGE_SIZE (`CS_IMAGE_WIDTH * `CS_IMAGE_HEIGHT)

// input channels folded into each output pixel
`define CS_CHANNEL_NUM 3

// index widths, never narrower than one bit
`define CS_ADDR_WIDTH ((`CS_IMAGE_SIZE > 1) ? $clog2(`CS_IMAGE_SIZE) : 1)
`define CS_CHAN_WIDTH ((`CS_CHANNEL_NUM > 1) ? $clog2(`CS_CHANNEL_NUM) : 1)

`endif
